//--- icache.f
+incdir+design
design/icache_pkg.sv
design/axi_rd_pkg.sv
design/line_fill_if.sv
design/cache_way.sv
design/icache_ctrl.sv
design/icache_top.sv
tb/tb_clk_gen.sv
tb/icache_tb.sv

//--- tb/icache_tb.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_tb
	import icache_pkg::*;
();

	// run length and timeout
	localparam int n_random = 120;
	localparam int n_requests = 2 * n_random + 6 + `ICACHE_WORDS;
	localparam int max_gap = 3;
	// miss, grant, address, 16 beats, settle, accept
	localparam int worst_refill = 4 + (`ICACHE_WORDS + 2) * (max_gap + 2);
	localparam int cycle_limit = n_requests * 2 * worst_refill;

	logic clk;
	logic rst_n;
	logic cpu_re;
	logic [31:0] cpu_addr;
	word_t cpu_rdata;
	logic cpu_stall;
	logic bus_req;
	logic bus_grnt;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	word_t rdata;
	logic rvalid;
	logic rready;

	// lcg state, stimulus and bus delays
	logic [31:0] stim_seed;
	logic [31:0] bus_seed;
	bit slow_bus;
	int wait_cnt;
	// responder burst pointer
	logic [31:0] rsp_addr;

	// reference model, tags, valid and lru per set
	tag_t m_tag [2][`ICACHE_SETS];
	bit m_valid [2][`ICACHE_SETS];
	bit m_lru [`ICACHE_SETS];

	// bus monitor
	int ar_count;
	int beat_count;
	logic [31:0] hs_addr;
	bit ar_wait;
	logic [31:0] ar_hold;
	bit data_due;
	word_t data_exp;

	int err_count;
	int check_count;
	int test_count;
	int test_err_base;
	int cycles;

	tb_clk_gen #(.half_period(10), .reset_cycles(10)) u_clk (.clk(clk), .rst_n(rst_n));

	icache_top dut (.*);

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// memory word, scrambled from the full word address
	function automatic word_t mem_word(input logic [31:0] addr);
		logic [29:0] w;
		w = addr[31:2];
		return ({2'b00, w} * 32'h9e3779b1) ^ {w[13:0], w[29:12]} ^ 32'h0f1e2d3c;
	endfunction

	// three tags, so two ways per set overflow
	function automatic tag_t pool_tag(input logic [1:0] k);
		case (k)
			2'd0: return 20'h00010;
			2'd1: return 20'h00abc;
			default: return 20'h7f001;
		endcase
	endfunction

	// model way holding the address, -1 on a miss
	function automatic int model_way(input cpu_addr_t a);
		int way;
		way = -1;
		for (int w = 0; w < 2; w++)
		begin
			if (m_valid[w][a.index] && m_tag[w][a.index] == a.tag)
				way = w;
		end
		return way;
	endfunction

	// hold-off before a bus response, none on a fast bus
	function automatic bit bus_ready();
		if (wait_cnt == 0)
		begin
			bus_seed = lcg(bus_seed);
			wait_cnt = slow_bus ? int'(bus_seed[17:16]) : 0;
			return 1'b1;
		end
		wait_cnt--;
		return 1'b0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
		check_count++;
		if (act !== exp)
		begin
			err_count++;
			$display("error %s exp=%h act=%h", name, exp, act);
		end
	endtask

	// memory responder, grant, address and data channels
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			bus_grnt <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			wait_cnt = 0;
		end
		else
		begin
			// burst pointer follows the transfers of this edge
			if (arvalid && arready)
				rsp_addr = araddr;
			else if (rvalid && rready)
				rsp_addr = rsp_addr + 32'd4;
			// grant held until the request drops
			bus_grnt <= bus_req && (bus_grnt || bus_ready());
			arready <= arvalid && !arready && bus_ready();
			rvalid <= rready && bus_ready();
			rdata <= mem_word(rsp_addr);
		end
	end

	// monitor, sampled mid-cycle
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			// read accepted on the previous edge
			if (data_due)
				check_value("cpu_rdata", cpu_rdata, data_exp);
			data_due = cpu_re && !cpu_stall;
			data_exp = mem_word(cpu_addr);
			// address held until arready
			if (ar_wait && !arvalid)
			begin
				err_count++;
				$display("error: arvalid dropped before arready was seen");
			end
			else if (ar_wait)
				check_value("araddr", araddr, ar_hold);
			ar_wait = arvalid && !arready;
			ar_hold = araddr;
			if (arvalid && arready)
			begin
				ar_count++;
				hs_addr = araddr;
			end
			if (rvalid && rready)
				beat_count++;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout after %0d cycles, a read never completed", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// one read, held while stalled, compared with the model
	task automatic fetch(input cpu_addr_t a, output bit was_miss);
		int way;
		int ar0;
		int beat0;
		int stalled;
		way = model_way(a);
		ar0 = ar_count;
		beat0 = beat_count;
		stalled = 0;
		@(posedge clk);
		cpu_re <= 1'b1;
		cpu_addr <= a;
		@(negedge clk);
		while (cpu_stall)
		begin
			stalled++;
			@(negedge clk);
		end
		// accepted on this edge
		@(posedge clk);
		cpu_re <= 1'b0;
		was_miss = (stalled != 0);
		check_count++;
		if (was_miss != (way < 0))
		begin
			err_count++;
			$display("error: read of %h stalled %0d cycles but the model predicted a %s",
				a, stalled, (way < 0) ? "miss" : "hit");
		end
		// one handshake and a full burst per miss, no bus traffic on a hit
		check_value("arvalid handshakes", ar_count - ar0, (way < 0) ? 1 : 0);
		check_value("rvalid beats", beat_count - beat0, (way < 0) ? `ICACHE_WORDS : 0);
		if (way < 0)
		begin
			check_value("araddr", hs_addr, {a.tag, a.index, 6'd0});
			// victim named by the lru bit
			way = m_lru[a.index];
			m_tag[way][a.index] = a.tag;
			m_valid[way][a.index] = 1'b1;
		end
		m_lru[a.index] = (way == 0);
	endtask

	// random tags over sets 0 to 3
	task automatic random_reads(input int count);
		cpu_addr_t a;
		bit miss;
		for (int i = 0; i < count; i++)
		begin
			stim_seed = lcg(stim_seed);
			a.tag = pool_tag(stim_seed[17:16]);
			a.index = index_t'(stim_seed[21:20]);
			a.offset = stim_seed[27:24];
			a.byte_off = 2'b00;
			fetch(a, miss);
		end
	endtask

	// tag order 0 1 0 2 0 1 in one set, expected miss hit pattern M M H M H M
	task automatic lru_eviction(input index_t index);
		cpu_addr_t a;
		bit miss;
		logic [11:0] order;
		logic [5:0] exp_miss;
		order = 12'b01_00_10_00_01_00;
		exp_miss = 6'b101011;
		for (int i = 0; i < 6; i++)
		begin
			a.tag = pool_tag(order[2*i +: 2]);
			a.index = index;
			a.offset = offset_t'(3 * i);
			a.byte_off = 2'b00;
			fetch(a, miss);
			check_value("cpu_stall miss", miss, exp_miss[i]);
		end
	endtask

	// one read per cycle to a resident line
	task automatic back_to_back(input tag_t tag, input index_t index);
		cpu_addr_t a;
		a = '{tag: tag, index: index, offset: '0, byte_off: '0};
		for (int i = 0; i < `ICACHE_WORDS; i++)
		begin
			a.offset = offset_t'(i);
			@(posedge clk);
			cpu_re <= 1'b1;
			cpu_addr <= a;
			@(negedge clk);
			check_value("cpu_stall", cpu_stall, 1'b0);
			m_lru[index] = (model_way(a) == 0);
		end
		@(posedge clk);
		cpu_re <= 1'b0;
	endtask

	task automatic end_test(input string name);
		// room for the last data check
		repeat (2) @(posedge clk);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, err_count - test_err_base);
		test_err_base = err_count;
	endtask

	initial
	begin
		cpu_re = 1'b0;
		cpu_addr = '0;
		bus_grnt = 1'b0;
		arready = 1'b0;
		rdata = '0;
		rvalid = 1'b0;
		rsp_addr = '0;
		stim_seed = 32'd63752;
		bus_seed = 32'd63752;
		slow_bus = 1'b0;
		wait (rst_n === 1'b1);
		@(negedge clk);
		check_value("bus_req", bus_req, 1'b0);
		check_value("arvalid", arvalid, 1'b0);
		check_value("rready", rready, 1'b0);
		check_value("cpu_stall", cpu_stall, 1'b0);
		end_test("reset state");
		random_reads(n_random);
		end_test("random reads, bus without delays");
		// switch delay mode away from the responder edge
		@(negedge clk);
		slow_bus = 1'b1;
		random_reads(n_random);
		end_test("random reads, random bus delays");
		lru_eviction(index_t'(9));
		end_test("lru eviction in one set");
		// first tag of the pool is resident in set 9
		back_to_back(pool_tag(2'd0), index_t'(9));
		end_test("back-to-back hits");
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/10ps

// free-running clock and synchronous reset for the testbench
module tb_clk_gen
#(
	parameter int half_period = 10,
	parameter int reset_cycles = 10
)
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// reset low for a fixed number of rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- design/icache_top.sv
`timescale 1ns/10ps

module icache_top
	import icache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	// cpu fetch port
	input logic cpu_re,
	input logic [31:0] cpu_addr,
	output word_t cpu_rdata,
	output logic cpu_stall,
	// bus arbitration
	output logic bus_req,
	input logic bus_grnt,
	// read address channel
	output logic [31:0] araddr,
	output logic arvalid,
	input logic arready,
	// read data channel
	input word_t rdata,
	input logic rvalid,
	output logic rready
);

	// split request address
	cpu_addr_t req_addr;

	// per-way lookup results
	logic hit0;
	logic hit1;
	word_t way0_rdata;
	word_t way1_rdata;

	// refill bundle shared by both ways
	line_fill_if fill_bus ();

	assign req_addr = cpu_addr_t'(cpu_addr);

	// way 0
	cache_way #(.WAY_ID(1'b0)) u_way0
	(
		.clk (clk),
		.rst_n (rst_n),
		.req_addr (req_addr),
		.fill (fill_bus.sink),
		.hit (hit0),
		.rdata (way0_rdata)
	);

	// way 1
	cache_way #(.WAY_ID(1'b1)) u_way1
	(
		.clk (clk),
		.rst_n (rst_n),
		.req_addr (req_addr),
		.fill (fill_bus.sink),
		.hit (hit1),
		.rdata (way1_rdata)
	);

	// miss handling, lru and bus side
	icache_ctrl u_ctrl
	(
		.clk (clk),
		.rst_n (rst_n),
		.cpu_re (cpu_re),
		.req_addr (req_addr),
		.hit0 (hit0),
		.hit1 (hit1),
		.way0_rdata (way0_rdata),
		.way1_rdata (way1_rdata),
		.cpu_rdata (cpu_rdata),
		.cpu_stall (cpu_stall),
		.fill (fill_bus.source),
		.bus_req (bus_req),
		.bus_grnt (bus_grnt),
		.araddr (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata (rdata),
		.rvalid (rvalid),
		.rready (rready)
	);

endmodule

//--- design/icache_ctrl.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_ctrl
	import icache_pkg::*;
	import axi_rd_pkg::*;
(
	input logic clk,
	input logic rst_n,
	// cpu fetch side
	input logic cpu_re,
	input cpu_addr_t req_addr,
	// way lookup results
	input logic hit0,
	input logic hit1,
	input word_t way0_rdata,
	input word_t way1_rdata,
	output word_t cpu_rdata,
	output logic cpu_stall,
	// refill writes into the ways
	line_fill_if.source fill,
	// bus arbitration
	output logic bus_req,
	input logic bus_grnt,
	// read address channel
	output logic [31:0] araddr,
	output logic arvalid,
	input logic arready,
	// read data channel
	input word_t rdata,
	input logic rvalid,
	output logic rready
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	// open bus handshake, decoded from state
	rd_phase_t rd_phase;

	// line base of the miss
	cpu_addr_t line_addr;

	// way being refilled
	logic victim;

	// next offset to fill
	beat_t beat;

	// per-set lru, names the victim way
	logic [`ICACHE_SETS-1:0] lru;

	// way that hit on the last accepted read
	logic hit_way_q;

	logic any_hit;
	logic miss;
	logic accept;
	logic beat_xfer;
	logic last_beat;

	assign any_hit = hit0 || hit1;

	// stall on any non-idle state or a lookup miss
	assign cpu_stall = (state != st_idle) || (cpu_re && !any_hit);
	assign accept = cpu_re && !cpu_stall;
	assign miss = (state == st_idle) && cpu_re && !any_hit;

	// beats arrive in order, counter ends the burst
	assign beat_xfer = (rd_phase == ph_data) && rvalid;
	assign last_beat = (beat == beat_t'(`ICACHE_BURST_LEN - 1));

	// handshake phase per state
	always_comb
	begin
		case (state)
			st_addr_phase: rd_phase = ph_address;
			st_data_phase: rd_phase = ph_data;
			default: rd_phase = ph_none;
		endcase
	end

	// request held from bus_request through the last beat
	assign bus_req = (state == st_bus_request) || (rd_phase != ph_none);
	assign arvalid = (rd_phase == ph_address);
	assign rready = (rd_phase == ph_data);
	// stable while arvalid waits
	assign araddr = line_addr;

	// refill write straight from the beat
	assign fill.we = beat_xfer;
	assign fill.way = victim;
	assign fill.index = line_addr.index;
	assign fill.offset = beat;
	assign fill.tag = line_addr.tag;
	assign fill.data = rdata;
	assign fill.last = last_beat;

	// pick the word of the way that hit
	assign cpu_rdata = hit_way_q ? way1_rdata : way0_rdata;

	// next state
	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
			begin
				if (miss)
					next_state = st_bus_request;
			end
			st_bus_request:
			begin
				// wait for the arbiter
				if (bus_grnt)
					next_state = st_addr_phase;
			end
			st_addr_phase:
			begin
				if (arready)
					next_state = st_data_phase;
			end
			st_data_phase:
			begin
				if (beat_xfer && last_beat)
					next_state = st_settle;
			end
			// one cycle so the new line is visible to lookup
			st_settle: next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

	// control state
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			beat <= '0;
			lru <= '0;
			hit_way_q <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (miss)
				beat <= '0;
			else if (beat_xfer)
				beat <= beat + 1'b1;
			// hit in way 0 points lru at way 1, and the reverse
			if (accept)
			begin
				lru[req_addr.index] <= hit0;
				hit_way_q <= hit1;
			end
			// finished fill points lru away from the victim
			if (beat_xfer && last_beat)
				lru[line_addr.index] <= ~victim;
		end
	end

	// miss capture
	always_ff @(posedge clk)
	begin
		if (miss)
		begin
			// line base, offset and byte zero
			line_addr <= '{tag: req_addr.tag, index: req_addr.index, offset: '0, byte_off: '0};
			victim <= lru[req_addr.index];
		end
	end

endmodule

//--- design/cache_way.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module cache_way
	import icache_pkg::*;
#(
	// way identity, 0 or 1
	parameter bit WAY_ID = 1'b0
)
(
	input logic clk,
	input logic rst_n,
	// current request address
	input cpu_addr_t req_addr,
	// refill writes
	line_fill_if.sink fill,
	// valid and tag match, combinational
	output logic hit,
	// word of the request, one cycle later
	output word_t rdata
);

	// per-set tag store
	tag_t tag_mem [`ICACHE_SETS];

	// per-set valid bits
	logic [`ICACHE_SETS-1:0] valid;

	// line data, set by word
	word_t data_mem [`ICACHE_SETS][`ICACHE_WORDS];

	// fill beat aimed at this way
	logic fill_wr;

	assign fill_wr = fill.we && (fill.way == WAY_ID);

	// lookup in the request cycle
	assign hit = valid[req_addr.index] && (tag_mem[req_addr.index] == req_addr.tag);

	// valid bits
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid <= '0;
		end
		else if (fill_wr)
		begin
			// line invalid while the burst is in progress
			// set again only by the last beat
			valid[fill.index] <= fill.last;
		end
	end

	// tag and data arrays
	always_ff @(posedge clk)
	begin
		if (fill_wr)
		begin
			// same tag rewritten on every beat
			tag_mem[fill.index] <= fill.tag;
			data_mem[fill.index][fill.offset] <= fill.data;
		end
	end

	// registered read of the indexed word
	always_ff @(posedge clk)
	begin
		// taken every cycle
		// controller picks the way a cycle later
		rdata <= data_mem[req_addr.index][req_addr.offset];
	end

endmodule

//--- design/line_fill_if.sv
`timescale 1ns/10ps
`include "icache_params.svh"

// refill write bundle, controller to both ways
interface line_fill_if;

	// one-cycle write strobe per beat
	logic we;
	// target way
	logic way;
	logic [`ICACHE_INDEX_W-1:0] index;
	logic [`ICACHE_OFFSET_W-1:0] offset;
	logic [`ICACHE_TAG_W-1:0] tag;
	logic [`ICACHE_DATA_W-1:0] data;
	// beat completes the line, sets valid
	logic last;

	// driven by the controller
	modport source
	(
		output we, way, index, offset, tag, data, last
	);

	// read by each way
	modport sink
	(
		input we, way, index, offset, tag, data, last
	);

endinterface

//--- design/axi_rd_pkg.sv
`include "icache_params.svh"

package axi_rd_pkg;

	// refill beat counter, wide enough for one burst
	typedef logic [$clog2(`ICACHE_BURST_LEN)-1:0] beat_t;

	// which read-channel handshake is open
	typedef enum logic [1:0]
	{
		// no bus traffic
		ph_none,
		// arvalid up, waiting for arready
		ph_address,
		// rready up, taking beats
		ph_data
	} rd_phase_t;

endpackage

//--- design/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

	// address fields
	typedef logic [`ICACHE_TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_INDEX_W-1:0] index_t;
	typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

	// cpu address split, msb first
	typedef struct packed
	{
		tag_t tag;
		index_t index;
		offset_t offset;
		// byte within the word, ignored for fetch
		logic [1:0] byte_off;
	} cpu_addr_t;

	// one instruction word
	typedef logic [`ICACHE_DATA_W-1:0] word_t;

	// controller states
	typedef enum logic [2:0]
	{
		st_idle,
		st_bus_request,
		st_addr_phase,
		st_data_phase,
		st_settle
	} ctrl_state_t;

endpackage

//--- design/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry for the two-way instruction cache
// tag, index, offset and byte field add up to a 32-bit address

// tag bits above the set index
`define ICACHE_TAG_W 20

// set index width, 64 sets
`define ICACHE_INDEX_W 6

// word offset within a line
`define ICACHE_OFFSET_W 4

// derived counts, kept in step with the widths above
`define ICACHE_SETS 64
`define ICACHE_WORDS 16

// instruction word width
`define ICACHE_DATA_W 32

// refill burst, one beat per word of the line
`define ICACHE_BURST_LEN 16

`endif
